/* vlog.f */
source/quad_bram_ctrl_pkg.sv
source/pfb_if.sv
source/exec_if.sv
source/pfb_fetch.sv
source/job_sequencer.sv
source/exec_timing.sv
source/quad_bram_ctrl.sv
testbench/quad_bram_ctrl_chk.sv
testbench/tb_quad_bram_ctrl.sv

/* testbench/tb_quad_bram_ctrl.sv */
`timescale 1ns/1ps

module tb_quad_bram_ctrl;
    import quad_bram_ctrl_pkg::*;

    localparam int NUM_JOBS = 3;

    logic       clk                = 1'b0;
    logic       rst                = 1'b1;
    coord_t     num_input_cols     = '0;
    coord_t     num_input_rows     = '0;
    logic       job_start          = 1'b0;
    logic       job_fetch_ack      = 1'b0;
    logic       job_fetch_complete = 1'b0;
    logic       job_complete_ack   = 1'b0;
    pfb_count_t pfb_full_count     = '0;
    logic       row_matric         = 1'b0;
    logic       last_kernel        = 1'b0;
    logic       next_row           = 1'b0;

    logic       job_accept;
    logic       job_fetch_request;
    logic       job_complete;
    logic       pfb_rden;
    coord_t     wr_addr;
    coord_t     input_row;
    coord_t     input_col;
    logic       seq_rden;
    logic [7:0] ce_start;
    cycle_t     cycle_counter;
    gray_t      gray_code;
    logic       pixel_dataout_valid;

    int job_cols [NUM_JOBS];
    int job_rows [NUM_JOBS];
    int cycle_limit = 0;
    int cycles      = 0;
    int tb_errors   = 0;
    int reads       = 0;
    int cur_cols    = 0;
    int pass_jobs   = 0;
    int fail_jobs   = 0;
    bit load_seen   = 1'b0;
    bit in_exec     = 1'b0;

    always #2 clk = ~clk;

    quad_bram_ctrl dut (.*);

    // Testbench misses plus failed assertions in the bound checker
    function automatic int total_errors();
        return tb_errors + dut.u_chk.err_count;
    endfunction

    //////////////////////////////
    // Environment models
    //////////////////////////////

    // Watchdog
    always @(posedge clk) begin
        cycles = cycles + 1;
        if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
            $display("Timeout after %0d cycles, a job never completed", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // Fetch engine acks after 1 to 4 cycles and completes 2 to 5 later
    always begin
        @(posedge clk);
        if (job_fetch_request && !job_fetch_ack) begin
            repeat ($urandom_range(1, 4)) @(negedge clk);
            job_fetch_ack = 1'b1;
            @(negedge clk);
            job_fetch_ack = 1'b0;
            repeat ($urandom_range(2, 5) - 1) @(negedge clk);
            job_fetch_complete = 1'b1;
            @(negedge clk);
            job_fetch_complete = 1'b0;
        end
    end

    // Each load is read out as one full padded row
    always @(posedge clk) begin
        if (job_fetch_complete) begin
            if (load_seen) begin
                assert (reads == cur_cols + 1) else begin
                    $display("ERR %0t pfb_rden reads expected %0d got %0d",
                             $time, cur_cols + 1, reads);
                    tb_errors = tb_errors + 1;
                end
            end
            reads     = 0;
            load_seen = 1'b1;
        end else if (pfb_rden) begin
            reads = reads + 1;
        end
    end

    // Execution side follows the sequencer read
    always @(posedge clk) begin
        in_exec = seq_rden;
    end

    always @(negedge clk) begin
        if (in_exec) begin
            next_row    = $urandom_range(0, 1);
            row_matric  = ($urandom_range(0, 3) != 0);
            last_kernel = ($urandom_range(0, 3) != 0);
        end else begin
            next_row    = 1'b0;
            row_matric  = 1'b0;
            last_kernel = 1'b0;
        end
    end

    // Complete ack 1 to 3 cycles after job_complete
    always begin
        @(posedge clk);
        if (job_complete && !job_complete_ack) begin
            repeat ($urandom_range(1, 3)) @(negedge clk);
            job_complete_ack = 1'b1;
            @(negedge clk);
            job_complete_ack = 1'b0;
        end
    end

    //////////////////////////////
    // Jobs
    //////////////////////////////

    task automatic run_job(input int idx);
        int errs_before;
        int errs;
        errs_before = total_errors();
        @(negedge clk);
        cur_cols       = job_cols[idx];
        num_input_cols = coord_t'(job_cols[idx]);
        num_input_rows = coord_t'(job_rows[idx]);
        pfb_full_count = pfb_count_t'(job_cols[idx] + 1);
        load_seen      = 1'b0;
        job_start      = 1'b1;
        @(negedge clk);
        job_start = 1'b0;
        // Idle controller takes the job on the first edge
        assert (job_accept === 1'b1) else begin
            $display("ERR %0t job_accept expected 1 got %b", $time, job_accept);
            tb_errors = tb_errors + 1;
        end
        @(posedge job_complete);
        @(negedge job_complete);
        // Let the FSM settle back in idle
        repeat (8) @(negedge clk);
        errs = total_errors() - errs_before;
        if (errs == 0) begin
            pass_jobs = pass_jobs + 1;
        end else begin
            fail_jobs = fail_jobs + 1;
        end
        $display("job %0d cols=%0d rows=%0d wr_addr=%0d errors=%0d %s",
                 idx, job_cols[idx], job_rows[idx], wr_addr, errs,
                 (errs == 0) ? "pass" : "FAIL");
    endtask

    initial begin
        int max_size;
        void'($urandom(32'h9c0d9b8f));
        max_size = 0;
        for (int i = 0; i < NUM_JOBS; i++) begin
            job_cols[i] = $urandom_range(3, 6);
            job_rows[i] = $urandom_range(5, 7);
            if ((job_rows[i] + 1) * (job_cols[i] + 1) > max_size) begin
                max_size = (job_rows[i] + 1) * (job_cols[i] + 1);
            end
        end
        cycle_limit = 3 * max_size * 40;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_JOBS; i++) begin
            run_job(i);
        end
        $display("jobs passed %0d failed %0d, check errors %0d",
                 pass_jobs, fail_jobs, total_errors());
        if ((fail_jobs == 0) && (total_errors() == 0)) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* testbench/quad_bram_ctrl_chk.sv */
`timescale 1ns/1ps

module quad_bram_ctrl_chk #(
    parameter int CE_W = 8
) (
    input logic                              clk,
    input logic                              rst,
    input quad_bram_ctrl_pkg::ctrl_state_t   state,
    input quad_bram_ctrl_pkg::coord_t        num_input_cols,
    input quad_bram_ctrl_pkg::coord_t        num_input_rows,
    input logic                              job_start,
    input logic                              job_accept,
    input logic                              job_fetch_request,
    input logic                              job_fetch_ack,
    input logic                              job_complete,
    input logic                              job_complete_ack,
    input logic                              pfb_rden,
    input quad_bram_ctrl_pkg::coord_t        wr_addr,
    input quad_bram_ctrl_pkg::coord_t        input_row,
    input quad_bram_ctrl_pkg::coord_t        input_col,
    input logic                              next_row,
    input logic                              seq_rden,
    input logic [CE_W-1:0]                   ce_start,
    input quad_bram_ctrl_pkg::cycle_t        cycle_counter,
    input quad_bram_ctrl_pkg::gray_t         gray_code,
    input logic                              pixel_dataout_valid
);
    import quad_bram_ctrl_pkg::*;

    // Running count of failed assertions
    int err_count = 0;
    // next_row pulses seen while active in the current job
    int nr_count;

    always_ff @(posedge clk) begin
        if (rst || ((state == ST_IDLE) && job_start)) begin
            nr_count <= 0;
        end else if ((state == ST_ACTIVE) && next_row) begin
            nr_count <= nr_count + 1;
        end
    end

    //////////////////////////////
    // Job and fetch handshakes
    //////////////////////////////

    a_accept_len: assert property (@(posedge clk) disable iff (rst)
        ((state == ST_IDLE) && job_start) |=> job_accept [*ACCEPT_CYCLES] ##1 !job_accept)
        else begin
            $error("job_accept not high for the accept window");
            err_count = err_count + 1;
        end

    a_accept_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(job_accept) |-> $past((state == ST_IDLE) && job_start))
        else begin
            $error("job_accept rose without an accepted job_start");
            err_count = err_count + 1;
        end

    // Request stays up until one cycle after the ack
    a_req_drop: assert property (@(posedge clk) disable iff (rst)
        (job_fetch_request && job_fetch_ack) |=> !job_fetch_request)
        else begin
            $error("job_fetch_request still high after ack");
            err_count = err_count + 1;
        end

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(job_fetch_request) |-> $past(job_fetch_ack))
        else begin
            $error("job_fetch_request fell without ack");
            err_count = err_count + 1;
        end

    //////////////////////////////
    // Write side
    //////////////////////////////

    a_wr_addr: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |=> wr_addr == coord_t'($past(wr_addr) + 1'b1))
        else begin
            $error("wr_addr did not step on a read");
            err_count = err_count + 1;
        end

    a_col_step: assert property (@(posedge clk) disable iff (rst)
        (pfb_rden && (input_col != num_input_cols))
            |=> (input_col == coord_t'($past(input_col) + 1'b1)) && $stable(input_row))
        else begin
            $error("input_col did not advance");
            err_count = err_count + 1;
        end

    a_col_wrap: assert property (@(posedge clk) disable iff (rst)
        (pfb_rden && (input_col == num_input_cols))
            |=> (input_col == '0) && (input_row == coord_t'($past(input_row) + 1'b1)))
        else begin
            $error("input row wrap wrong");
            err_count = err_count + 1;
        end

    //////////////////////////////
    // Execution timing
    //////////////////////////////

    // Sequencer reads through the active phase except on the last pulse of a row
    a_seq_rden: assert property (@(posedge clk) disable iff (rst)
        1'b1 |-> seq_rden == ((state == ST_ACTIVE) &&
                              !(next_row && ((nr_count % (int'(num_input_cols) + 1)) ==
                                             int'(num_input_cols)))))
        else begin
            $error("seq_rden wrong for the active phase and row end");
            err_count = err_count + 1;
        end

    // First CE follows the active phase by a cycle
    a_ce_first: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> ce_start[0] == $past(state == ST_ACTIVE))
        else begin
            $error("ce_start bit 0 not a delayed active phase");
            err_count = err_count + 1;
        end

    // Each CE bit trails the one below by a cycle
    for (genvar i = 1; i < CE_W; i++) begin : g_ce
        a_ce_cascade: assert property (@(posedge clk) disable iff (rst)
            1'b1 |=> ce_start[i] == $past(ce_start[i-1]))
            else begin
                $error("ce_start cascade broken");
                err_count = err_count + 1;
            end
    end

    a_pix_valid: assert property (@(posedge clk) disable iff (rst)
        1'b1 |-> ##DOUT_VALID_DELAY pixel_dataout_valid == $past(seq_rden, DOUT_VALID_DELAY))
        else begin
            $error("pixel_dataout_valid not a delayed seq_rden");
            err_count = err_count + 1;
        end

    // Counter step lands one sample after the delayed read
    a_cycle_step: assert property (@(posedge clk) disable iff (rst)
        seq_rden |-> ##(CYCLE_INC_DELAY+1)
            cycle_counter == (($past(cycle_counter) == cycle_t'(SEQ_PHASES - 1)) ?
                              cycle_t'(0) : cycle_t'($past(cycle_counter) + 1'b1)))
        else begin
            $error("cycle_counter did not step mod 5");
            err_count = err_count + 1;
        end

    a_cycle_hold: assert property (@(posedge clk) disable iff (rst)
        !seq_rden |-> ##(CYCLE_INC_DELAY+1) $stable(cycle_counter))
        else begin
            $error("cycle_counter moved without a read");
            err_count = err_count + 1;
        end

    a_gray_step: assert property (@(posedge clk) disable iff (rst)
        next_row |=> $countones(gray_code ^ $past(gray_code)) == 1)
        else begin
            $error("gray_code changed by other than one bit");
            err_count = err_count + 1;
        end

    a_gray_hold: assert property (@(posedge clk) disable iff (rst)
        !next_row |=> $stable(gray_code))
        else begin
            $error("gray_code moved without next_row");
            err_count = err_count + 1;
        end

    //////////////////////////////
    // Job completion
    //////////////////////////////

    a_done_count: assert property (@(posedge clk) disable iff (rst)
        $rose(job_complete)
            |-> nr_count == (int'(num_input_rows) + 1) * (int'(num_input_cols) + 1))
        else begin
            $error("job_complete before all output pixels");
            err_count = err_count + 1;
        end

    a_done_hold: assert property (@(posedge clk) disable iff (rst)
        (job_complete && !job_complete_ack) |=> job_complete)
        else begin
            $error("job_complete dropped without ack");
            err_count = err_count + 1;
        end

    a_done_drop: assert property (@(posedge clk) disable iff (rst)
        (job_complete && job_complete_ack) |=> !job_complete)
        else begin
            $error("job_complete still high after ack");
            err_count = err_count + 1;
        end

endmodule

bind quad_bram_ctrl quad_bram_ctrl_chk #(
    .CE_W (NUM_AWE * NUM_CE_PER_AWE)
) u_chk (
    .clk                 (clk),
    .rst                 (rst),
    .state               (u_seq.state),
    .num_input_cols      (num_input_cols),
    .num_input_rows      (num_input_rows),
    .job_start           (job_start),
    .job_accept          (job_accept),
    .job_fetch_request   (job_fetch_request),
    .job_fetch_ack       (job_fetch_ack),
    .job_complete        (job_complete),
    .job_complete_ack    (job_complete_ack),
    .pfb_rden            (pfb_rden),
    .wr_addr             (wr_addr),
    .input_row           (input_row),
    .input_col           (input_col),
    .next_row            (next_row),
    .seq_rden            (seq_rden),
    .ce_start            (ce_start),
    .cycle_counter       (cycle_counter),
    .gray_code           (gray_code),
    .pixel_dataout_valid (pixel_dataout_valid)
);

/* source/quad_bram_ctrl.sv */
`timescale 1ns/1ps

module quad_bram_ctrl #(
    parameter int NUM_AWE        = 4,
    parameter int NUM_CE_PER_AWE = 2
) (
    input  logic                              clk,
    input  logic                              rst,
    input  quad_bram_ctrl_pkg::coord_t        num_input_cols,
    input  quad_bram_ctrl_pkg::coord_t        num_input_rows,
    // Job handshake
    input  logic                              job_start,
    output logic                              job_accept,
    output logic                              job_fetch_request,
    input  logic                              job_fetch_ack,
    input  logic                              job_fetch_complete,
    output logic                              job_complete,
    input  logic                              job_complete_ack,
    // Prefetch buffer
    input  quad_bram_ctrl_pkg::pfb_count_t    pfb_full_count,
    output logic                              pfb_rden,
    output quad_bram_ctrl_pkg::coord_t        wr_addr,
    output quad_bram_ctrl_pkg::coord_t        input_row,
    output quad_bram_ctrl_pkg::coord_t        input_col,
    // Execution
    input  logic                              row_matric,
    input  logic                              last_kernel,
    input  logic                              next_row,
    output logic                              seq_rden,
    output logic [NUM_AWE*NUM_CE_PER_AWE-1:0] ce_start,
    output quad_bram_ctrl_pkg::cycle_t        cycle_counter,
    output quad_bram_ctrl_pkg::gray_t         gray_code,
    output logic                              pixel_dataout_valid
);

    pfb_if  pfb_bus ();
    exec_if exe_bus ();

    // Fetch side
    pfb_fetch u_fetch (
        .clk                (clk),
        .rst                (rst),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .pfb_full_count     (pfb_full_count),
        .num_input_cols     (num_input_cols),
        .pfb                (pfb_bus),
        .input_col          (input_col)
    );

    // Job control
    job_sequencer u_seq (
        .clk               (clk),
        .rst               (rst),
        .job_start         (job_start),
        .job_fetch_ack     (job_fetch_ack),
        .job_complete_ack  (job_complete_ack),
        .row_matric        (row_matric),
        .last_kernel       (last_kernel),
        .pfb               (pfb_bus),
        .exe               (exe_bus),
        .job_accept        (job_accept),
        .job_fetch_request (job_fetch_request),
        .job_complete      (job_complete),
        .wr_addr           (wr_addr)
    );

    // AWE timing
    exec_timing #(
        .NUM_AWE        (NUM_AWE),
        .NUM_CE_PER_AWE (NUM_CE_PER_AWE)
    ) u_exec (
        .clk                 (clk),
        .rst                 (rst),
        .next_row            (next_row),
        .num_input_cols      (num_input_cols),
        .num_input_rows      (num_input_rows),
        .exe                 (exe_bus),
        .ce_start            (ce_start),
        .cycle_counter       (cycle_counter),
        .gray_code           (gray_code),
        .pixel_dataout_valid (pixel_dataout_valid)
    );

    assign pfb_rden  = pfb_bus.pfb_rden;
    assign input_row = pfb_bus.input_row;
    assign seq_rden  = exe_bus.seq_rden;

endmodule

/* source/exec_timing.sv */
`timescale 1ns/1ps

module exec_timing #(
    parameter int NUM_AWE        = 4,
    parameter int NUM_CE_PER_AWE = 2
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  next_row,
    input  quad_bram_ctrl_pkg::coord_t            num_input_cols,
    input  quad_bram_ctrl_pkg::coord_t            num_input_rows,
    exec_if.exec                                  exe,
    output logic [NUM_AWE*NUM_CE_PER_AWE-1:0]     ce_start,
    output quad_bram_ctrl_pkg::cycle_t            cycle_counter,
    output quad_bram_ctrl_pkg::gray_t             gray_code,
    output logic                                  pixel_dataout_valid
);
    import quad_bram_ctrl_pkg::*;

    localparam int CE_W = NUM_AWE * NUM_CE_PER_AWE;

    coord_t                      output_row;
    coord_t                      output_col;
    logic                        last_col;
    logic [DOUT_VALID_DELAY-1:0] rden_dly;
    logic                        cycle_inc;
    gray_t                       row_cnt;

    //////////////////////////////
    // Output position
    //////////////////////////////

    assign last_col = (output_col == num_input_cols);

    // Row closes on the next_row at the last column
    assign exe.row_end  = exe.active && next_row && last_col;
    assign exe.last_row = (output_row == num_input_rows);

    always_ff @(posedge clk) begin
        if (rst || exe.job_begin) begin
            output_col <= '0;
            output_row <= '0;
        end else if (exe.row_end) begin
            output_col <= '0;
            output_row <= output_row + 1'b1;
        end else if (exe.active && next_row) begin
            output_col <= output_col + 1'b1;
        end
    end

    //////////////////////////////
    // CE start cascade
    //////////////////////////////

    // One CE switched on per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ce_start <= '0;
        end else begin
            ce_start <= {ce_start[CE_W-2:0], exe.active};
        end
    end

    //////////////////////////////
    // Sequencer delay taps
    //////////////////////////////

    // Bit n holds seq_rden from n+1 cycles back
    always_ff @(posedge clk) begin
        if (rst) begin
            rden_dly <= '0;
        end else begin
            rden_dly <= {rden_dly[DOUT_VALID_DELAY-2:0], exe.seq_rden};
        end
    end

    assign cycle_inc           = rden_dly[CYCLE_INC_DELAY-1];
    assign pixel_dataout_valid = rden_dly[DOUT_VALID_DELAY-1];

    // Phase counter, wraps after the last phase
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_counter <= '0;
        end else if (cycle_inc) begin
            if (cycle_counter == cycle_t'(SEQ_PHASES - 1)) begin
                cycle_counter <= '0;
            end else begin
                cycle_counter <= cycle_counter + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Row select
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            row_cnt <= '0;
        end else if (next_row) begin
            row_cnt <= row_cnt + 1'b1;
        end
    end

    // Binary to gray, one bit flips per step
    assign gray_code = {row_cnt[1], row_cnt[1] ^ row_cnt[0]};

endmodule

/* source/job_sequencer.sv */
`timescale 1ns/1ps

module job_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       job_start,
    input  logic                       job_fetch_ack,
    input  logic                       job_complete_ack,
    input  logic                       row_matric,
    input  logic                       last_kernel,
    pfb_if.seq                         pfb,
    exec_if.seq                        exe,
    output logic                       job_accept,
    output logic                       job_fetch_request,
    output logic                       job_complete,
    output quad_bram_ctrl_pkg::coord_t wr_addr
);
    import quad_bram_ctrl_pkg::*;

    ctrl_state_t              state;
    ctrl_state_t              state_nxt;
    ctrl_state_t              ret_state;
    logic [ACCEPT_CYCLES-1:0] accept_sr;
    logic                     job_begin;
    logic                     pfb_empty;
    logic                     prime_done;
    logic                     go_fetch;
    logic                     complete_seen;

    //////////////////////////////
    // Status decode
    //////////////////////////////

    assign pfb_empty  = (pfb.pfb_count == '0);
    // All priming rows have gone through the buffer
    assign prime_done = (pfb.input_row == coord_t'(PRIME_ROWS));

    // Job taken only from idle
    assign job_begin     = (state == ST_IDLE) && job_start;
    assign pfb.job_begin = job_begin;
    assign exe.job_begin = job_begin;

    // Complete handshake closes on the first ack with complete up
    assign complete_seen = job_complete && job_complete_ack;

    //////////////////////////////
    // Job FSM
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        go_fetch  = 1'b0;
        case (state)
            ST_IDLE: begin
                if (job_start) begin
                    state_nxt = ST_PRIME;
                end
            end
            ST_PRIME: begin
                // Refill until the priming rows are in
                if (pfb_empty) begin
                    if (prime_done) begin
                        state_nxt = ST_ACTIVE;
                    end else begin
                        go_fetch  = 1'b1;
                        state_nxt = ST_WAIT_FETCH;
                    end
                end
            end
            ST_WAIT_FETCH: begin
                if (pfb.load_done) begin
                    state_nxt = ret_state;
                end
            end
            ST_ACTIVE: begin
                // Decisions only at an output row boundary
                if (exe.row_end) begin
                    if (exe.last_row) begin
                        state_nxt = ST_DONE;
                    end else if (pfb_empty) begin
                        go_fetch  = 1'b1;
                        state_nxt = ST_WAIT_FETCH;
                    end
                end
            end
            ST_DONE: begin
                if (complete_seen) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            ret_state <= ST_IDLE;
        end else begin
            state <= state_nxt;
            // Where to resume once the row has landed
            if (go_fetch) begin
                ret_state <= state;
            end
        end
    end

    //////////////////////////////
    // Handshakes
    //////////////////////////////

    // Accept pulse walks through the stages
    always_ff @(posedge clk) begin
        if (rst) begin
            accept_sr <= '0;
        end else begin
            accept_sr <= {accept_sr[ACCEPT_CYCLES-2:0], job_begin};
        end
    end

    assign job_accept = |accept_sr;

    // Request raised with the wait state, dropped after the ack
    always_ff @(posedge clk) begin
        if (rst) begin
            job_fetch_request <= 1'b0;
        end else if (go_fetch) begin
            job_fetch_request <= 1'b1;
        end else if (job_fetch_ack) begin
            job_fetch_request <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            job_complete <= 1'b0;
        end else if (complete_seen) begin
            job_complete <= 1'b0;
        end else if (state == ST_DONE) begin
            job_complete <= 1'b1;
        end
    end

    //////////////////////////////
    // Read strobes
    //////////////////////////////

    // Priming drains freely, active drains on the last kernel of a row
    assign pfb.pfb_rden = !pfb_empty &&
                          ((state == ST_PRIME) ||
                           ((state == ST_ACTIVE) && row_matric && last_kernel));

    // One BRAM write per PFB read
    always_ff @(posedge clk) begin
        if (rst || job_begin) begin
            wr_addr <= '0;
        end else if (pfb.pfb_rden) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    assign exe.active   = (state == ST_ACTIVE);
    // Sequencer pauses for the row end cycle
    assign exe.seq_rden = (state == ST_ACTIVE) && !exe.row_end;

endmodule

/* source/pfb_fetch.sv */
`timescale 1ns/1ps

module pfb_fetch (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           job_fetch_ack,
    input  logic                           job_fetch_complete,
    input  quad_bram_ctrl_pkg::pfb_count_t pfb_full_count,
    input  quad_bram_ctrl_pkg::coord_t     num_input_cols,
    pfb_if.fetch                           pfb,
    output quad_bram_ctrl_pkg::coord_t     input_col
);
    import quad_bram_ctrl_pkg::*;

    fetch_state_t fetch_state;
    pfb_count_t   count;
    coord_t       row;
    logic         col_wrap;

    //////////////////////////////
    // Fetch response FSM
    //////////////////////////////

    // Ack opens the row request, complete closes it
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_state <= FETCH_IDLE;
        end else begin
            case (fetch_state)
                FETCH_IDLE: begin
                    if (job_fetch_ack) begin
                        fetch_state <= FETCH_ROW_REQ;
                    end
                end
                FETCH_ROW_REQ: begin
                    if (job_fetch_complete) begin
                        fetch_state <= FETCH_IDLE;
                    end
                end
                default: fetch_state <= FETCH_IDLE;
            endcase
        end
    end

    // Single cycle, only for an acknowledged request
    assign pfb.load_done = (fetch_state == FETCH_ROW_REQ) && job_fetch_complete;

    //////////////////////////////
    // PFB occupancy
    //////////////////////////////

    // Load and read never overlap, reads need a non-empty buffer
    always_ff @(posedge clk) begin
        if (rst || pfb.job_begin) begin
            count <= '0;
        end else if (pfb.load_done) begin
            count <= pfb_full_count;
        end else if (pfb.pfb_rden) begin
            count <= count - 1'b1;
        end
    end

    assign pfb.pfb_count = count;

    //////////////////////////////
    // Input position
    //////////////////////////////

    // Last entry of a padded row
    assign col_wrap = (input_col == num_input_cols);

    always_ff @(posedge clk) begin
        if (rst || pfb.job_begin) begin
            input_col <= '0;
            row       <= '0;
        end else if (pfb.pfb_rden) begin
            if (col_wrap) begin
                input_col <= '0;
                row       <= row + 1'b1;
            end else begin
                input_col <= input_col + 1'b1;
            end
        end
    end

    assign pfb.input_row = row;

endmodule

/* source/exec_if.sv */
`timescale 1ns/1ps

// Link between the job sequencer and the execution timing
interface exec_if;

    // Sequencer side
    logic job_begin;
    logic active;
    logic seq_rden;
    // Output row tracking
    logic row_end;
    logic last_row;

    modport seq (
        output job_begin,
        output active,
        output seq_rden,
        input  row_end,
        input  last_row
    );

    modport exec (
        input  job_begin,
        input  active,
        input  seq_rden,
        output row_end,
        output last_row
    );

endinterface

/* source/pfb_if.sv */
`timescale 1ns/1ps

// Link between the fetch side and the job sequencer
interface pfb_if;
    import quad_bram_ctrl_pkg::*;

    // Sequencer strobes
    logic       job_begin;
    logic       pfb_rden;
    // Fetch side status
    logic       load_done;
    pfb_count_t pfb_count;
    coord_t     input_row;

    modport fetch (
        input  job_begin,
        input  pfb_rden,
        output load_done,
        output pfb_count,
        output input_row
    );

    modport seq (
        output job_begin,
        output pfb_rden,
        input  load_done,
        input  pfb_count,
        input  input_row
    );

endinterface

/* source/quad_bram_ctrl_pkg.sv */
package quad_bram_ctrl_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    // Depth of one quad-BRAM
    localparam int BRAM_DEPTH = 1024;
    // Row, column and address width, one bit short of the depth
    localparam int COORD_W = $clog2(BRAM_DEPTH) - 1;

    typedef logic [COORD_W-1:0] coord_t;
    // Prefetch buffer occupancy
    typedef logic [8:0]         pfb_count_t;
    // Sequencer phase, 0 to 4
    typedef logic [2:0]         cycle_t;
    // Row select into the AWE line buffers
    typedef logic [1:0]         gray_t;

    //////////////////////////////
    // Timing
    //////////////////////////////

    // Padded rows loaded before the AWEs start
    localparam int PRIME_ROWS       = 4;
    // Sequencer period
    localparam int SEQ_PHASES       = 5;
    // Width of the accept pulse
    localparam int ACCEPT_CYCLES    = 5;
    // Sequencer read to cycle count step
    localparam int CYCLE_INC_DELAY  = 2;
    // Sequencer read to pixel valid
    localparam int DOUT_VALID_DELAY = 3;

    //////////////////////////////
    // State machines
    //////////////////////////////

    // Job control
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRIME,
        ST_WAIT_FETCH,
        ST_ACTIVE,
        ST_DONE
    } ctrl_state_t;

    // Fetch engine response tracking
    typedef enum logic {
        FETCH_IDLE,
        FETCH_ROW_REQ
    } fetch_state_t;

endpackage
